// ==== verilog/soc_config.svh ====
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// Boot memory window
`define BOOT_BASE 32'h0201_0000
`define BOOT_ADDR_BITS 15
`define BOOT_WORDS 8192 // 32-bit words

// Gamepad register, one word
`define GAMEPAD_BASE 32'h0200_0200
`define GAMEPAD_ADDR_BITS 2

// Scanner pacing
`define GP_TICK_DIV 1024 // clk_50mhz cycles per tick
`define GP_BUTTONS 8 // Buttons per controller

`endif

// ==== verilog/soc_pkg.sv ====
package soc_pkg;

	typedef logic [31:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [3:0] axil_strb_t;

	typedef enum logic [1:0] {
		resp_okay = 2'b00,
		resp_slverr = 2'b10,
		resp_decerr = 2'b11
	} axil_resp_e;

	typedef struct packed {
		axil_addr_t addr;
		logic valid;
	} axil_aw_t;

	typedef struct packed {
		axil_data_t data;
		axil_strb_t strb;
		logic valid;
	} axil_w_t;

	typedef struct packed {
		axil_resp_e resp;
		logic valid;
	} axil_b_t;

	typedef struct packed {
		axil_addr_t addr;
		logic valid;
	} axil_ar_t;

	typedef struct packed {
		axil_data_t data;
		axil_resp_e resp;
		logic valid;
	} axil_r_t;

	// Master to slave
	typedef struct packed {
		axil_aw_t aw;
		axil_w_t w;
		axil_ar_t ar;
		logic bready;
		logic rready;
	} axil_req_t;

	// Slave to master
	typedef struct packed {
		logic awready;
		logic wready;
		logic arready;
		axil_b_t b;
		axil_r_t r;
	} axil_rsp_t;

	typedef enum logic [1:0] {target_boot, target_gamepad, target_none} target_e;

	typedef enum logic [1:0] {scan_idle, scan_latch, scan_sample, scan_pulse} scan_state_e;

endpackage

// ==== verilog/axil_decoder.sv ====
`include "soc_config.svh"

module axil_decoder (
	input  logic               clk_50mhz,
	input  logic               resetn,
	input  soc_pkg::axil_req_t host_req,
	output soc_pkg::axil_rsp_t host_rsp,
	output soc_pkg::axil_req_t boot_req,
	input  soc_pkg::axil_rsp_t boot_rsp,
	output soc_pkg::axil_req_t pad_req,
	input  soc_pkg::axil_rsp_t pad_rsp
);
	import soc_pkg::*;

	localparam axil_addr_t boot_base = `BOOT_BASE;
	localparam axil_addr_t gamepad_base = `GAMEPAD_BASE;

	target_e aw_tgt;
	target_e w_tgt;
	target_e ar_tgt;
	target_e wr_tgt; // Held until the B transfer
	target_e rd_tgt; // Held until the R transfer
	logic aw_done;
	logic w_done;
	logic rd_done;
	logic loc_bvalid;
	logic loc_rvalid;
	logic w_open;
	logic aw_fire;
	logic w_fire;
	logic b_fire;
	logic ar_fire;
	logic r_fire;

	function automatic target_e decode(input axil_addr_t addr);
		if (addr[31:`BOOT_ADDR_BITS] == boot_base[31:`BOOT_ADDR_BITS])
			return target_boot;
		if (addr[31:`GAMEPAD_ADDR_BITS] == gamepad_base[31:`GAMEPAD_ADDR_BITS])
			return target_gamepad;
		return target_none;
	endfunction

	assign aw_tgt = decode(host_req.aw.addr);
	assign ar_tgt = decode(host_req.ar.addr);
	assign w_tgt = aw_done ? wr_tgt : aw_tgt; // Pending aw address is stable, so W may go early
	assign w_open = host_req.w.valid && !w_done && (aw_done || host_req.aw.valid);

	always_comb begin
		boot_req = '0;
		pad_req = '0;
		boot_req.aw.addr = host_req.aw.addr;
		boot_req.aw.valid = host_req.aw.valid && !aw_done && aw_tgt == target_boot;
		boot_req.w.data = host_req.w.data;
		boot_req.w.strb = host_req.w.strb;
		boot_req.w.valid = w_open && w_tgt == target_boot;
		boot_req.bready = host_req.bready && aw_done && wr_tgt == target_boot;
		boot_req.ar.addr = host_req.ar.addr;
		boot_req.ar.valid = host_req.ar.valid && !rd_done && ar_tgt == target_boot;
		boot_req.rready = host_req.rready && rd_done && rd_tgt == target_boot;
		pad_req.ar.addr = host_req.ar.addr; // Gamepad only ever sees reads
		pad_req.ar.valid = host_req.ar.valid && !rd_done && ar_tgt == target_gamepad;
		pad_req.rready = host_req.rready && rd_done && rd_tgt == target_gamepad;
	end

	always_comb begin
		host_rsp = '0;
		host_rsp.awready = host_req.aw.valid && !aw_done &&
			(aw_tgt == target_boot ? boot_rsp.awready : 1'b1);
		host_rsp.wready = w_open && (w_tgt == target_boot ? boot_rsp.wready : 1'b1);
		case (ar_tgt)
			target_boot: host_rsp.arready = host_req.ar.valid && !rd_done && boot_rsp.arready;
			target_gamepad: host_rsp.arready = host_req.ar.valid && !rd_done && pad_rsp.arready;
			default: host_rsp.arready = host_req.ar.valid && !rd_done;
		endcase
		if (aw_done && wr_tgt == target_boot) begin
			host_rsp.b = boot_rsp.b;
		end else begin
			host_rsp.b.valid = loc_bvalid;
			host_rsp.b.resp = (wr_tgt == target_gamepad) ? resp_slverr : resp_decerr;
		end
		if (rd_done && rd_tgt == target_boot) begin
			host_rsp.r = boot_rsp.r;
		end else if (rd_done && rd_tgt == target_gamepad) begin
			host_rsp.r = pad_rsp.r;
		end else begin
			host_rsp.r.valid = loc_rvalid;
			host_rsp.r.resp = resp_decerr; // Data stays zero
		end
	end

	assign aw_fire = host_req.aw.valid && host_rsp.awready;
	assign w_fire = host_req.w.valid && host_rsp.wready;
	assign b_fire = host_rsp.b.valid && host_req.bready;
	assign ar_fire = host_req.ar.valid && host_rsp.arready;
	assign r_fire = host_rsp.r.valid && host_req.rready;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			aw_done <= 1'b0;
			w_done <= 1'b0;
			loc_bvalid <= 1'b0;
			wr_tgt <= target_none;
		end else if (b_fire) begin
			aw_done <= 1'b0;
			w_done <= 1'b0;
			loc_bvalid <= 1'b0;
		end else begin
			if (aw_fire) begin
				aw_done <= 1'b1;
				wr_tgt <= aw_tgt;
			end
			if (w_fire)
				w_done <= 1'b1;
			// Local answer once both halves are in
			if ((aw_done || aw_fire) && (w_done || w_fire) && w_tgt != target_boot)
				loc_bvalid <= 1'b1;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			rd_done <= 1'b0;
			loc_rvalid <= 1'b0;
			rd_tgt <= target_none;
		end else if (r_fire) begin
			rd_done <= 1'b0;
			loc_rvalid <= 1'b0;
		end else if (ar_fire) begin
			rd_done <= 1'b1;
			rd_tgt <= ar_tgt;
			loc_rvalid <= ar_tgt == target_none;
		end
	end

endmodule

// ==== verilog/boot_memory.sv ====
`include "soc_config.svh"

module boot_memory (
	input  logic               clk_50mhz,
	input  logic               resetn,
	input  soc_pkg::axil_req_t req,
	output soc_pkg::axil_rsp_t rsp
);
	import soc_pkg::*;

	axil_data_t mem [`BOOT_WORDS];
	logic aw_full;
	logic w_full;
	axil_addr_t aw_addr;
	axil_data_t w_data;
	axil_strb_t w_strb;
	logic bvalid;
	logic rvalid;
	axil_data_t rdata;
	logic aw_fire;
	logic w_fire;
	logic ar_fire;
	logic do_write;
	axil_addr_t wr_addr;
	axil_data_t wr_data;
	axil_strb_t wr_strb;

	assign rsp.awready = req.aw.valid && !aw_full && !bvalid;
	assign rsp.wready = req.w.valid && !w_full && !bvalid;
	assign rsp.arready = req.ar.valid && !rvalid;
	assign rsp.b.valid = bvalid;
	assign rsp.b.resp = resp_okay;
	assign rsp.r.data = rdata;
	assign rsp.r.resp = resp_okay;
	assign rsp.r.valid = rvalid;

	assign aw_fire = req.aw.valid && rsp.awready;
	assign w_fire = req.w.valid && rsp.wready;
	assign ar_fire = req.ar.valid && rsp.arready;

	// Held beat, or the one transferring now
	assign wr_addr = aw_full ? aw_addr : req.aw.addr;
	assign wr_data = w_full ? w_data : req.w.data;
	assign wr_strb = w_full ? w_strb : req.w.strb;
	assign do_write = (aw_full || aw_fire) && (w_full || w_fire);

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			aw_full <= 1'b0;
			w_full <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (do_write) begin
				aw_full <= 1'b0;
				w_full <= 1'b0;
				bvalid <= 1'b1;
			end else begin
				if (aw_fire)
					aw_full <= 1'b1;
				if (w_fire)
					w_full <= 1'b1;
				if (bvalid && req.bready)
					bvalid <= 1'b0;
			end
			if (ar_fire)
				rvalid <= 1'b1;
			else if (rvalid && req.rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (aw_fire)
			aw_addr <= req.aw.addr;
		if (w_fire) begin
			w_data <= req.w.data;
			w_strb <= req.w.strb;
		end
		if (ar_fire)
			rdata <= mem[req.ar.addr[`BOOT_ADDR_BITS-1:2]];
		if (do_write) begin
			for (int i = 0; i < 4; i++) begin
				if (wr_strb[i])
					mem[wr_addr[`BOOT_ADDR_BITS-1:2]][8*i +: 8] <= wr_data[8*i +: 8];
			end
		end
	end

endmodule

// ==== verilog/gamepad_scanner.sv ====
`include "soc_config.svh"

module gamepad_scanner (
	input  logic                       clk_50mhz,
	input  logic                       resetn,
	input  logic [1:0]                 pad_data,
	output logic [1:0]                 pad_latch,
	output logic [1:0]                 pad_clk,
	output logic [2*`GP_BUTTONS-1:0]   buttons,
	output logic                       buttons_valid
);
	import soc_pkg::*;

	localparam int div_bits = $clog2(`GP_TICK_DIV);
	localparam int cnt_bits = $clog2(`GP_BUTTONS);
	localparam logic [cnt_bits-1:0] last_bit = cnt_bits'(`GP_BUTTONS - 1);

	logic [div_bits-1:0] div_cnt;
	logic tick;
	scan_state_e state;
	logic [cnt_bits-1:0] bit_cnt;
	logic [`GP_BUTTONS-1:0] work0; // Controller 0 shift register
	logic [`GP_BUTTONS-1:0] work1;

	assign tick = div_cnt == div_bits'(`GP_TICK_DIV - 1);
	assign pad_latch = {2{state == scan_latch}};
	assign pad_clk = {2{state == scan_pulse}};

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			div_cnt <= '0;
			state <= scan_idle;
			bit_cnt <= '0;
			buttons_valid <= 1'b0;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick) begin
				case (state)
					scan_idle: state <= scan_latch;
					scan_latch: begin
						state <= scan_sample;
						bit_cnt <= '0;
					end
					scan_sample: state <= scan_pulse;
					scan_pulse: begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == last_bit) begin
							state <= scan_idle;
							buttons_valid <= 1'b1; // First full scan done
						end else begin
							state <= scan_sample;
						end
					end
					default: state <= scan_idle;
				endcase
			end
		end
	end

	always_ff @(posedge clk_50mhz) begin
		// Sample at the end of the low tick, first bit ends up in bit 0
		if (tick && state == scan_sample) begin
			work0 <= {~pad_data[0], work0[`GP_BUTTONS-1:1]};
			work1 <= {~pad_data[1], work1[`GP_BUTTONS-1:1]};
		end
		if (tick && state == scan_pulse && bit_cnt == last_bit)
			buttons <= {work1, work0};
	end

endmodule

// ==== verilog/gamepad_slave.sv ====
`include "soc_config.svh"

module gamepad_slave (
	input  logic                       clk_50mhz,
	input  logic                       resetn,
	input  soc_pkg::axil_req_t         req,
	output soc_pkg::axil_rsp_t         rsp,
	input  logic [2*`GP_BUTTONS-1:0]   buttons,
	input  logic                       buttons_valid
);
	import soc_pkg::*;

	logic rvalid;
	axil_data_t rdata;
	logic ar_fire;

	always_comb begin
		rsp = '0; // Writes are answered by the decoder
		rsp.arready = req.ar.valid && !rvalid;
		rsp.r.data = rdata;
		rsp.r.resp = resp_okay;
		rsp.r.valid = rvalid;
	end

	assign ar_fire = req.ar.valid && rsp.arready;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn)
			rvalid <= 1'b0;
		else if (ar_fire)
			rvalid <= 1'b1;
		else if (rvalid && req.rready)
			rvalid <= 1'b0;
	end

	// Snapshot taken at the address, held under back-pressure
	always_ff @(posedge clk_50mhz) begin
		if (ar_fire)
			rdata <= {buttons_valid, {(31 - 2*`GP_BUTTONS){1'b0}}, buttons};
	end

endmodule

// ==== verilog/soc_top.sv ====
module soc_top (
	input  logic               clk_50mhz,
	input  logic               resetn,
	input  soc_pkg::axil_req_t host_req,
	output soc_pkg::axil_rsp_t host_rsp,
	input  logic [1:0]         pad_data,
	output logic [1:0]         pad_latch,
	output logic [1:0]         pad_clk
);
	soc_pkg::axil_req_t boot_req;
	soc_pkg::axil_rsp_t boot_rsp;
	soc_pkg::axil_req_t pad_req;
	soc_pkg::axil_rsp_t pad_rsp;
	logic [15:0] buttons;
	logic buttons_valid;

	axil_decoder decoder (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.host_req(host_req),
		.host_rsp(host_rsp),
		.boot_req(boot_req),
		.boot_rsp(boot_rsp),
		.pad_req(pad_req),
		.pad_rsp(pad_rsp)
	);

	boot_memory boot (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.req(boot_req),
		.rsp(boot_rsp)
	);

	gamepad_slave pad_reg (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.req(pad_req),
		.rsp(pad_rsp),
		.buttons(buttons),
		.buttons_valid(buttons_valid)
	);

	gamepad_scanner scanner (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.pad_data(pad_data),
		.pad_latch(pad_latch),
		.pad_clk(pad_clk),
		.buttons(buttons),
		.buttons_valid(buttons_valid)
	);

endmodule

// ==== testbench/soc_chk.sv ====
`include "soc_config.svh"

module soc_chk (
	input logic               clk_50mhz,
	input logic               resetn,
	input soc_pkg::axil_req_t host_req,
	input soc_pkg::axil_rsp_t host_rsp,
	input logic [1:0]         pad_latch,
	input logic [1:0]         pad_clk
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0; // Bumped by every failing assertion
	int latch_len;
	int clk_len;
	int clk_pulses;
	logic clk_prev;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			latch_len <= 0;
			clk_len <= 0;
			clk_pulses <= `GP_BUTTONS; // Nothing to count before the first latch
			clk_prev <= 1'b0;
		end else begin
			latch_len <= pad_latch[0] ? latch_len + 1 : 0;
			clk_len <= pad_clk[0] ? clk_len + 1 : 0;
			clk_prev <= pad_clk[0];
			if (pad_latch[0])
				clk_pulses <= 0;
			else if (pad_clk[0] && !clk_prev)
				clk_pulses <= clk_pulses + 1;
		end
	end

	assert property (@(posedge clk_50mhz) disable iff (!resetn)
		host_rsp.r.valid && !host_req.rready |=> host_rsp.r.valid && $stable(host_rsp.r))
	else begin
		fail_count++;
		$error("Read response dropped or changed while rready was low");
	end

	assert property (@(posedge clk_50mhz) disable iff (!resetn)
		host_rsp.b.valid && !host_req.bready |=> host_rsp.b.valid && $stable(host_rsp.b))
	else begin
		fail_count++;
		$error("Write response dropped or changed while bready was low");
	end

	// One transaction in flight per direction
	assert property (@(posedge clk_50mhz) disable iff (!resetn)
		!(host_rsp.r.valid && host_rsp.arready) && !(host_rsp.b.valid && host_rsp.awready))
	else begin
		fail_count++;
		$error("A new address was accepted while a response was pending");
	end

	assert property (@(posedge clk_50mhz) disable iff (!resetn)
		host_req.ar.valid && host_rsp.arready |=> host_rsp.r.valid)
	else begin
		fail_count++;
		$error("rvalid did not follow the read address one cycle later");
	end

	assert property (@(posedge clk_50mhz) disable iff (!resetn)
		$fell(pad_latch[0]) |-> latch_len == `GP_TICK_DIV)
	else begin
		fail_count++;
		$error("pad_latch pulse width is not one tick");
	end

	assert property (@(posedge clk_50mhz) disable iff (!resetn)
		$fell(pad_clk[0]) |-> clk_len == `GP_TICK_DIV)
	else begin
		fail_count++;
		$error("pad_clk pulse width is not one tick");
	end

	assert property (@(posedge clk_50mhz) disable iff (!resetn)
		$rose(pad_latch[0]) |-> clk_pulses == `GP_BUTTONS)
	else begin
		fail_count++;
		$error("Wrong number of pad_clk pulses between two latches");
	end

endmodule

bind soc_top soc_chk chk (.*);

// ==== testbench/soc_tb.sv ====
`include "soc_config.svh"

// Serial game controller model whose line reads low while a button is pressed
module pad_shifter (
	input  logic       latch,
	input  logic       shift_clk,
	input  logic [7:0] pattern,
	output logic       data
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [7:0] line_bits = '1;

	assign data = line_bits[0];

	always @(posedge latch) begin
		#1 line_bits = ~pattern;
	end

	always @(posedge shift_clk) begin
		#1 line_bits = {1'b1, line_bits[7:1]};
	end

endmodule

module soc_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import soc_pkg::*;

	localparam int cycle_limit = 3 * 18 * `GP_TICK_DIV + 5000; // Three scans plus bus traffic
	localparam axil_addr_t boot_addr = `BOOT_BASE;
	localparam axil_addr_t pad_addr = `GAMEPAD_BASE;
	localparam axil_addr_t hole_addr = 32'h0301_0000; // Unmapped but its low bits alias boot word 0

	logic clk_50mhz = 1'b0;
	logic resetn;
	axil_req_t host_req;
	axil_rsp_t host_rsp;
	logic [1:0] pad_data;
	logic [1:0] pad_latch;
	logic [1:0] pad_clk;
	logic [7:0] pattern0;
	logic [7:0] pattern1;
	axil_data_t mirror [16];
	int seed = 32'h3a247d66;
	int cycles = 0;

	soc_top dut (.*);

	pad_shifter pad0 (
		.latch(pad_latch[0]), .shift_clk(pad_clk[0]), .pattern(pattern0), .data(pad_data[0])
	);
	pad_shifter pad1 (
		.latch(pad_latch[1]), .shift_clk(pad_clk[1]), .pattern(pattern1), .data(pad_data[1])
	);

	always #10 clk_50mhz = ~clk_50mhz;

	always @(posedge clk_50mhz) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles waiting for a handshake or a scan", cycles);
			$display("Regression failed");
			$fatal(1, "Timeout");
		end
	end

	always @(negedge clk_50mhz) begin
		if (dut.chk.fail_count != 0) begin
			$display("A bound protocol or timing assertion failed");
			$display("Regression failed");
			$fatal(1, "Assertion failure");
		end
	end

	task automatic next_cycle();
		@(posedge clk_50mhz);
		#2;
	endtask

	task automatic check_value(input string name, input axil_data_t exp, input axil_data_t act);
		assert (act === exp)
		else begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			$display("Regression failed");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic send_write(input axil_addr_t addr, input axil_data_t data,
			input axil_strb_t strb);
		int aw_wait;
		int w_wait;
		logic aw_hs;
		logic w_hs;
		logic [31:0] rnd;
		rnd = $random(seed);
		// Either channel may lead by a cycle, a pending address stays valid
		aw_wait = (rnd[1:0] == 2'd1 && !host_req.aw.valid) ? 1 : 0;
		w_wait = (rnd[1:0] == 2'd2) ? 1 : 0;
		host_req.aw.addr = addr;
		host_req.w.data = data;
		host_req.w.strb = strb;
		while (aw_wait >= 0 || w_wait >= 0) begin
			host_req.aw.valid = aw_wait == 0;
			host_req.w.valid = w_wait == 0;
			@(negedge clk_50mhz);
			aw_hs = host_req.aw.valid && host_rsp.awready;
			w_hs = host_req.w.valid && host_rsp.wready;
			next_cycle();
			if (aw_hs)
				aw_wait = -1;
			else if (aw_wait > 0)
				aw_wait--;
			if (w_hs)
				w_wait = -1;
			else if (w_wait > 0)
				w_wait--;
		end
		host_req.aw.valid = 1'b0;
		host_req.w.valid = 1'b0;
	endtask

	task automatic take_b(input string name, input axil_resp_e exp_resp, input logic stall);
		logic b_hs;
		logic [31:0] rnd;
		axil_resp_e resp;
		b_hs = 1'b0;
		while (!b_hs) begin
			rnd = $random(seed);
			host_req.bready = !stall || rnd[0];
			@(negedge clk_50mhz);
			b_hs = host_rsp.b.valid && host_req.bready;
			resp = host_rsp.b.resp;
			next_cycle();
		end
		host_req.bready = 1'b0;
		check_value({name, " bresp"}, 32'(exp_resp), 32'(resp));
	endtask

	task automatic write_word(input string name, input axil_addr_t addr, input axil_data_t data,
			input axil_strb_t strb, input axil_resp_e exp_resp, input logic stall);
		send_write(addr, data, strb);
		take_b(name, exp_resp, stall);
	endtask

	task automatic send_ar(input axil_addr_t addr);
		logic ar_hs;
		ar_hs = 1'b0;
		host_req.ar.addr = addr;
		host_req.ar.valid = 1'b1;
		while (!ar_hs) begin
			@(negedge clk_50mhz);
			ar_hs = host_rsp.arready;
			next_cycle();
		end
		host_req.ar.valid = 1'b0;
	endtask

	task automatic take_r(input string name, input axil_data_t exp_data,
			input axil_resp_e exp_resp, input logic stall);
		logic r_hs;
		logic [31:0] rnd;
		axil_r_t r;
		r_hs = 1'b0;
		while (!r_hs) begin
			rnd = $random(seed);
			host_req.rready = !stall || rnd[0];
			@(negedge clk_50mhz);
			r_hs = host_rsp.r.valid && host_req.rready;
			r = host_rsp.r;
			next_cycle();
		end
		host_req.rready = 1'b0;
		check_value({name, " rdata"}, exp_data, r.data);
		check_value({name, " rresp"}, 32'(exp_resp), 32'(r.resp));
	endtask

	initial begin
		axil_data_t data;
		logic [31:0] rnd;
		host_req = '0;
		pattern0 = '0;
		pattern1 = '0;
		resetn = 1'b0;
		repeat (2) next_cycle();
		resetn = 1'b1;

		// Known contents first, then random byte lanes on top
		for (int i = 0; i < 16; i++) begin
			mirror[i] = $random(seed);
			write_word("boot_fill", boot_addr + 32'(4 * i), mirror[i], 4'hf, resp_okay, 1'b0);
		end
		for (int i = 0; i < 16; i++) begin
			data = $random(seed);
			rnd = $random(seed);
			write_word("boot_strobe", boot_addr + 32'(4 * i), data, rnd[3:0], resp_okay, i[0]);
			for (int b = 0; b < 4; b++) begin
				if (rnd[b])
					mirror[i][8*b +: 8] = data[8*b +: 8];
			end
		end

		data = $random(seed);
		send_write(boot_addr, data, 4'hf);
		mirror[0] = data;
		host_req.aw.addr = boot_addr + 32'd4; // Waits behind the stalled write response
		host_req.aw.valid = 1'b1;
		take_b("boot_wpipe0", resp_okay, 1'b1);
		data = $random(seed);
		send_write(boot_addr + 32'd4, data, 4'hf);
		mirror[1] = data;
		take_b("boot_wpipe1", resp_okay, 1'b1);

		for (int i = 0; i < 16; i++) begin
			send_ar(boot_addr + 32'(4 * i));
			take_r("boot_read", mirror[i], resp_okay, i[0]);
		end

		send_ar(boot_addr);
		host_req.ar.addr = boot_addr + 32'd4; // Waits behind the stalled response
		host_req.ar.valid = 1'b1;
		take_r("boot_pipe0", mirror[0], resp_okay, 1'b1);
		send_ar(boot_addr + 32'd4);
		take_r("boot_pipe1", mirror[1], resp_okay, 1'b1);

		send_ar(hole_addr);
		take_r("hole_read", '0, resp_decerr, 1'b1);
		write_word("hole_write", hole_addr, 32'hdead_beef, 4'hf, resp_decerr, 1'b0);
		send_ar(boot_addr);
		take_r("hole_alias", mirror[0], resp_okay, 1'b0);

		rnd = $random(seed);
		pattern0 = rnd[7:0];
		pattern1 = rnd[15:8];
		// Loaded at the next latch, reported once that scan has ended
		@(posedge pad_latch[0]);
		@(posedge pad_latch[0]);
		next_cycle();
		send_ar(pad_addr);
		take_r("pad_read", {1'b1, 15'b0, pattern1, pattern0}, resp_okay, 1'b0);

		write_word("pad_write", pad_addr, 32'hffff_ffff, 4'hf, resp_slverr, 1'b1);
		send_ar(pad_addr);
		take_r("pad_reread", {1'b1, 15'b0, pattern1, pattern0}, resp_okay, 1'b1);

		next_cycle();
		if (dut.chk.fail_count != 0) begin
			$display("Regression failed");
			$fatal(1, "Bound assertions reported %0d failures", dut.chk.fail_count);
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

// ==== sim.f ====
+incdir+verilog
verilog/soc_pkg.sv
verilog/axil_decoder.sv
verilog/boot_memory.sv
verilog/gamepad_scanner.sv
verilog/gamepad_slave.sv
verilog/soc_top.sv
testbench/soc_chk.sv
testbench/soc_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --assert --timing
TOP = soc_tb
FILELIST = sim.f
OBJ_DIR = obj_dir
BIN = soc_sim
RUN_ARGS = +verilator+error+limit+100
PASS_MSG = Regression passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(BIN)
	@out="$$(./$(OBJ_DIR)/$(BIN) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
